/* bagman_shell.f */
hw/core_cfg_pkg.sv
hw/core_io_pkg.sv
hw/cfg_regs.sv
hw/player_map.sv
hw/av_out.sv
hw/bagman_shell.sv
verif/shell_assertions.sv
verif/tb_bagman_shell.sv

/* verif/tb_bagman_shell.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the bagman shell
// clock, reset, watchdog, value check and directed tests
//////////////////////////////////////////////////////////////////////

`default_nettype none

module tb_bagman_shell
    import core_cfg_pkg::*;
    import core_io_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period      = 100;
    localparam int num_tests       = 6;
    localparam int watchdog_cycles = num_tests * 400 + reset_pulse_cycles * 4;

    logic         clk_74a;
    logic         rst_n;
    logic         bridge_wr;
    bridge_addr_t bridge_addr;
    bridge_data_t bridge_wr_data;
    key_t         cont_key [num_players];
    logic         pix_ce;
    color3_t      pix_r;
    color3_t      pix_g;
    color2_t      pix_b;
    logic         hblank;
    logic         vblank;
    logic         core_hs;
    logic         core_vs;
    sound_t       sound;
    joy_port_t    joy_port [num_players];
    mode_t        core_mode;
    dip_t         dips;
    logic         core_reset;
    rgb_t         video_rgb;
    logic         video_de;
    logic         video_hs;
    logic         video_vs;
    sample_t      sample;

    integer seed = 3984;
    // core sync level at the last pix_ce update
    logic   hs_seen;
    logic   vs_seen;

    bagman_shell u_bagman_shell (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .cont_key       (cont_key),
        .pix_ce         (pix_ce),
        .pix_r          (pix_r),
        .pix_g          (pix_g),
        .pix_b          (pix_b),
        .hblank         (hblank),
        .vblank         (vblank),
        .core_hs        (core_hs),
        .core_vs        (core_vs),
        .sound          (sound),
        .joy_port       (joy_port),
        .core_mode      (core_mode),
        .dips           (dips),
        .core_reset     (core_reset),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs),
        .sample         (sample)
    );

    initial begin
        clk_74a = 1'b0;
        forever begin
            #(clk_period / 2) clk_74a = ~clk_74a;
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("simulation timed out before the tests completed");
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, actual, expected);
            $display("test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // one strobe cycle, called on a falling edge
    task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
    endtask

    ///////////////////////////////////////////////////////////////////////
    // reference rules
    ///////////////////////////////////////////////////////////////////////

    function automatic joy_port_t expected_joy(input key_t k, input int m, input int player);
        joy_port_t act;
        act    = '0;
        act[7] = k[key_fire1];
        if (m == 3) begin
            // dial code, down first
            if (k[key_down]) begin
                act[6:5] = 2'd1;
            end else if (k[key_up]) begin
                act[6:5] = 2'd2;
            end else begin
                act[6:5] = 2'd3;
            end
        end else begin
            act[6] = k[key_down];
            act[5] = k[key_up];
        end
        act[4] = k[key_right];
        act[3] = k[key_left];
        act[2] = k[key_start] | ((m == 4) & k[key_fire2]);
        act[1] = (player == 1) & (m == 1);
        act[0] = (player == 0) & k[key_coin];
        return ~act;
    endfunction

    function automatic rgb_t expected_rgb(input color3_t r, input color3_t g,
                                          input color2_t b, input logic blank,
                                          input mode_t m);
        rgb_t rgb;
        if (blank) begin
            rgb = (m == mode_squa) ? 24'h002000 : 24'h000000;
        end else begin
            rgb[23:16] = {r, r, r[2:1]};
            rgb[15:8]  = {g, g, g[2:1]};
            rgb[7:0]   = {b, b, b, b};
        end
        return rgb;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // directed tests
    ///////////////////////////////////////////////////////////////////////

    task automatic verify_reset_state();
        check_val(core_reset, 1'b0, "core_reset after reset");
        check_val(video_de, 1'b0, "video_de after reset");
        check_val(video_hs, 1'b0, "video_hs after reset");
        check_val(video_vs, 1'b0, "video_vs after reset");
        check_val(video_rgb, 24'h0, "video_rgb after reset");
        check_val(sample, 16'h0, "sample after reset");
        check_val(joy_port[0], 8'hff, "joy_port[0] after reset");
        check_val(joy_port[1], 8'hff, "joy_port[1] after reset");
        check_val(core_mode, mode_bagman, "core_mode after reset");
        check_val(dips, 8'h00, "dips after reset");
    endtask

    task automatic run_register_writes();
        // upper data bits must be dropped
        bridge_write(addr_mode, 32'habcd_ef02);
        check_val(core_mode, mode_pick, "core_mode after write");
        bridge_write(addr_dips, 32'h1234_56a5);
        check_val(dips, 8'ha5, "dips after write");
        // near misses of the register map
        bridge_write(32'h1000_0004, 32'h0000_0003);
        bridge_write(32'h2000_0001, 32'h0000_005a);
        bridge_write(32'h0000_0000, 32'hffff_ffff);
        check_val(core_mode, mode_pick, "core_mode after unmapped writes");
        check_val(dips, 8'ha5, "dips after unmapped writes");
        check_val(core_reset, 1'b0, "core_reset after unmapped writes");
    endtask

    task automatic measure_reset_pulse();
        int   high_cycles;
        int   rises;
        logic last;
        bridge_write(addr_reset, 32'h0000_0001);
        // first edge only flips the toggle
        check_val(core_reset, 1'b0, "core_reset one edge after write");
        @(negedge clk_74a);
        check_val(core_reset, 1'b1, "core_reset two edges after write");
        high_cycles = 0;
        rises       = 1;
        last        = 1'b1;
        for (int i = 0; i < 3 * reset_pulse_cycles; i++) begin
            if (core_reset) begin
                high_cycles++;
            end
            if (core_reset && !last) begin
                rises++;
            end
            last = core_reset;
            // second toggle lands mid pulse, address still points at reset
            bridge_wr = (i == 10);
            @(negedge clk_74a);
        end
        check_val(high_cycles, reset_pulse_cycles, "core_reset pulse length");
        check_val(rises, 1, "core_reset pulse count");
    endtask

    task automatic sweep_player_map();
        integer v;
        key_t   keys [num_players];
        // code 5 has no name and should act as bagman
        for (int m = 0; m < 6; m++) begin
            bridge_write(addr_mode, 32'(m));
            for (int n = 0; n < 8; n++) begin
                for (int p = 0; p < num_players; p++) begin
                    v           = $random(seed);
                    keys[p]     = v[15:0];
                    cont_key[p] = keys[p];
                end
                @(negedge clk_74a);
                for (int p = 0; p < num_players; p++) begin
                    check_val(joy_port[p], expected_joy(keys[p], m, p),
                              $sformatf("joy_port[%0d] mode %0d keys 0x%h", p, m, keys[p]));
                end
            end
        end
    endtask

    // one pix_ce update, then an idle cycle to see the outputs hold
    task automatic pix_update(input color3_t r, input color3_t g, input color2_t b,
                              input logic hb, input logic vb, input logic hs,
                              input logic vs, input mode_t m);
        rgb_t exp_rgb;
        logic exp_hs;
        logic exp_vs;
        exp_rgb = expected_rgb(r, g, b, hb | vb, m);
        exp_hs  = hs & ~hs_seen;
        exp_vs  = vs & ~vs_seen;
        hs_seen = hs;
        vs_seen = vs;
        pix_r   = r;
        pix_g   = g;
        pix_b   = b;
        hblank  = hb;
        vblank  = vb;
        core_hs = hs;
        core_vs = vs;
        pix_ce  = 1'b1;
        @(negedge clk_74a);
        pix_ce = 1'b0;
        check_val(video_rgb, exp_rgb, "video_rgb after update");
        check_val(video_de, !(hb | vb), "video_de after update");
        check_val(video_hs, exp_hs, "video_hs after update");
        check_val(video_vs, exp_vs, "video_vs after update");
        // scramble inputs, nothing may move without pix_ce
        pix_r   = ~r;
        pix_g   = ~g;
        pix_b   = ~b;
        hblank  = ~hb;
        core_hs = ~hs;
        core_vs = ~vs;
        @(negedge clk_74a);
        check_val(video_rgb, exp_rgb, "video_rgb held");
        check_val(video_de, !(hb | vb), "video_de held");
        check_val(video_hs, exp_hs, "video_hs held");
    endtask

    task automatic exercise_video();
        integer v;
        mode_t  m;
        m = mode_squa;
        for (int pass = 0; pass < 2; pass++) begin
            m = (pass == 0) ? mode_squa : mode_botanic;
            bridge_write(addr_mode, 32'(m));
            for (int n = 0; n < 12; n++) begin
                v = $random(seed);
                pix_update(v[2:0], v[5:3], v[7:6], v[8] & v[9], v[10] & v[11],
                           1'b0, 1'b0, m);
            end
        end
        // hsync held high gives a single pulse
        pix_update(3'd7, 3'd0, 2'd3, 1'b0, 1'b0, 1'b1, 1'b0, m);
        pix_update(3'd1, 3'd2, 2'd1, 1'b0, 1'b0, 1'b1, 1'b0, m);
        pix_update(3'd5, 3'd6, 2'd2, 1'b0, 1'b0, 1'b1, 1'b0, m);
        pix_update(3'd0, 3'd7, 2'd0, 1'b1, 1'b0, 1'b0, 1'b0, m);
        // same for vsync
        pix_update(3'd3, 3'd3, 2'd3, 1'b0, 1'b1, 1'b0, 1'b1, m);
        pix_update(3'd4, 3'd1, 2'd1, 1'b0, 1'b1, 1'b0, 1'b1, m);
    endtask

    task automatic sweep_audio();
        sound_t  v;
        sample_t want;
        integer  r;
        for (int n = 0; n < 11; n++) begin
            case (n)
                0: v = 13'd0;
                1: v = 13'd4096;
                2: v = 13'd8191;
                default: begin
                    r = $random(seed);
                    v = r[12:0];
                end
            endcase
            want  = sample_t'(int'(v) - 4096);
            sound = v;
            @(negedge clk_74a);
            check_val(sample, want, $sformatf("sample for sound %0d", v));
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // main sequence
    ///////////////////////////////////////////////////////////////////////

    initial begin
        rst_n          = 1'b0;
        bridge_wr      = 1'b0;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        cont_key[0]    = '0;
        cont_key[1]    = '0;
        pix_ce         = 1'b0;
        pix_r          = '0;
        pix_g          = '0;
        pix_b          = '0;
        hblank         = 1'b0;
        vblank         = 1'b0;
        core_hs        = 1'b0;
        core_vs        = 1'b0;
        // midpoint, so sample stays 0 out of reset
        sound          = 13'd4096;
        hs_seen        = 1'b0;
        vs_seen        = 1'b0;
        repeat (8) @(negedge clk_74a);
        rst_n = 1'b1;
        @(negedge clk_74a);
        verify_reset_state();
        run_register_writes();
        measure_reset_pulse();
        sweep_player_map();
        exercise_video();
        sweep_audio();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/shell_assertions.sv */
//////////////////////////////////////////////////////////////////////
// concurrent checks bound into the bagman shell top level
// core reset pulse length and origin, sync pulse width
//////////////////////////////////////////////////////////////////////

`default_nettype none

module shell_assertions
    import core_cfg_pkg::*;
(
    input wire logic         clk_74a,
    input wire logic         rst_n,
    input wire logic         bridge_wr,
    input wire bridge_addr_t bridge_addr,
    input wire logic         core_reset,
    input wire logic         pix_ce,
    input wire logic         video_hs,
    input wire logic         video_vs
);
    timeunit 1ns;
    timeprecision 1ps;

    // consecutive edges seen with core_reset high
    int high_run;

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            high_run <= 0;
        end else if (core_reset) begin
            high_run <= high_run + 1;
        end else begin
            high_run <= 0;
        end
    end

    // pulse never outlives its fixed length
    ap_reset_len : assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        !core_reset || (high_run < reset_pulse_cycles)
    ) else $error("core_reset held beyond %0d cycles", reset_pulse_cycles);

    // a rising core_reset needs a reset write two edges back
    ap_reset_cause : assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        $rose(core_reset) |-> $past(bridge_wr && (bridge_addr == addr_reset), 2)
    ) else $error("core_reset rose without a write to the reset address");

    // sync outputs last a single pix_ce update
    ap_hs_width : assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        (pix_ce && video_hs) |=> !video_hs
    ) else $error("video_hs high at two consecutive pixel updates");

    ap_vs_width : assert property (
        @(posedge clk_74a) disable iff (!rst_n)
        (pix_ce && video_vs) |=> !video_vs
    ) else $error("video_vs high at two consecutive pixel updates");

endmodule

bind bagman_shell shell_assertions u_shell_assertions (
    .clk_74a     (clk_74a),
    .rst_n       (rst_n),
    .bridge_wr   (bridge_wr),
    .bridge_addr (bridge_addr),
    .core_reset  (core_reset),
    .pix_ce      (pix_ce),
    .video_hs    (video_hs),
    .video_vs    (video_vs)
);

`default_nettype wire

/* hw/bagman_shell.sv */
//////////////////////////////////////////////////////////////////////
// bagman board glue top level
// config registers, two player mappers and the a/v output stage
//////////////////////////////////////////////////////////////////////

`default_nettype none

module bagman_shell
    import core_cfg_pkg::*;
    import core_io_pkg::*;
(
    input  wire logic         clk_74a,
    input  wire logic         rst_n,
    // bridge writes
    input  wire logic         bridge_wr,
    input  wire bridge_addr_t bridge_addr,
    input  wire bridge_data_t bridge_wr_data,
    // controllers
    input  wire key_t         cont_key [num_players],
    // core video and sound
    input  wire logic         pix_ce,
    input  wire color3_t      pix_r,
    input  wire color3_t      pix_g,
    input  wire color2_t      pix_b,
    input  wire logic         hblank,
    input  wire logic         vblank,
    input  wire logic         core_hs,
    input  wire logic         core_vs,
    input  wire sound_t       sound,
    // to the core
    output joy_port_t         joy_port [num_players],
    output mode_t             core_mode,
    output dip_t              dips,
    output logic              core_reset,
    // to the scaler and audio
    output rgb_t              video_rgb,
    output logic              video_de,
    output logic              video_hs,
    output logic              video_vs,
    output sample_t           sample
);

    // variant, dips and reset pulse
    cfg_regs u_cfg_regs (
        .clk_74a        (clk_74a),
        .rst_n          (rst_n),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .mode           (core_mode),
        .dips           (dips),
        .core_reset     (core_reset)
    );

    // one mapper per player, index selects coin/botanic bits
    for (genvar i = 0; i < num_players; i++) begin : g_player
        player_map #(
            .player_idx (i)
        ) u_player_map (
            .clk_74a  (clk_74a),
            .rst_n    (rst_n),
            .keys     (cont_key[i]),
            .mode     (core_mode),
            .joy_port (joy_port[i])
        );
    end

    av_out u_av_out (
        .clk_74a   (clk_74a),
        .rst_n     (rst_n),
        .pix_ce    (pix_ce),
        .pix_r     (pix_r),
        .pix_g     (pix_g),
        .pix_b     (pix_b),
        .hblank    (hblank),
        .vblank    (vblank),
        .core_hs   (core_hs),
        .core_vs   (core_vs),
        .mode      (core_mode),
        .sound     (sound),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_hs  (video_hs),
        .video_vs  (video_vs),
        .sample    (sample)
    );

endmodule

`default_nettype wire

/* hw/av_out.sv */
//////////////////////////////////////////////////////////////////////
// video output stage: 3-3-2 expansion, data enable, sync pulses
// and squa backdrop, plus sound to signed sample conversion
//////////////////////////////////////////////////////////////////////

`default_nettype none

module av_out
    import core_cfg_pkg::*;
    import core_io_pkg::*;
(
    input  wire logic    clk_74a,
    input  wire logic    rst_n,
    input  wire logic    pix_ce,
    input  wire color3_t pix_r,
    input  wire color3_t pix_g,
    input  wire color2_t pix_b,
    input  wire logic    hblank,
    input  wire logic    vblank,
    input  wire logic    core_hs,
    input  wire logic    core_vs,
    input  wire mode_t   mode,
    input  wire sound_t  sound,
    output rgb_t         video_rgb,
    output logic         video_de,
    output logic         video_hs,
    output logic         video_vs,
    output sample_t      sample
);

    logic blank;
    logic hs_prev;
    logic vs_prev;
    rgb_t pix_rgb;

    assign blank = hblank | vblank;

    // bit repeat so full scale maps to 0xff
    assign pix_rgb = {pix_r, pix_r, pix_r[2:1],
                      pix_g, pix_g, pix_g[2:1],
                      {4{pix_b}}};

    //////////////////////////////////////////////////////////////////
    // video, advances on pix_ce only
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
            hs_prev   <= 1'b0;
            vs_prev   <= 1'b0;
        end else if (pix_ce) begin
            video_de <= ~blank;
            if (!blank) begin
                video_rgb <= pix_rgb;
            end else if (mode == mode_squa) begin
                video_rgb <= squa_backdrop;
            end else begin
                video_rgb <= '0;
            end
            // rising edge of core sync, one update wide
            video_hs <= core_hs & ~hs_prev;
            video_vs <= core_vs & ~vs_prev;
            hs_prev  <= core_hs;
            vs_prev  <= core_vs;
        end
    end

    //////////////////////////////////////////////////////////////////
    // audio, every clock
    //////////////////////////////////////////////////////////////////

    // zero extend then remove bias
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            sample <= sample_t'({{($bits(sample_t) - $bits(sound_t)){1'b0}}, sound})
                      - sound_offset;
        end
    end

endmodule

`default_nettype wire

/* hw/player_map.sv */
//////////////////////////////////////////////////////////////////////
// one player's key map to active low core joystick port
// variant dependent, registered
//////////////////////////////////////////////////////////////////////

`default_nettype none

module player_map
    import core_cfg_pkg::*;
    import core_io_pkg::*;
#(
    parameter int player_idx = 0
) (
    input  wire logic  clk_74a,
    input  wire logic  rst_n,
    input  wire key_t  keys,
    input  wire mode_t mode,
    output joy_port_t  joy_port
);

    logic      is_squa;
    logic      is_sbag;
    logic      is_botanic;
    logic [1:0] vert;
    logic      btn_start;
    logic      bit1;
    logic      bit0;
    joy_port_t joy_hi;

    // unnamed codes match none of these, so act as bagman
    assign is_squa    = (mode == mode_squa);
    assign is_sbag    = (mode == mode_sbag);
    assign is_botanic = (mode == mode_botanic);

    // squa reads a dial in place of up/down
    // down wins over up
    always_comb begin
        if (!is_squa) begin
            vert = {keys[key_down], keys[key_up]};
        end else if (keys[key_down]) begin
            vert = 2'd1;
        end else if (keys[key_up]) begin
            vert = 2'd2;
        end else begin
            vert = 2'd3;
        end
    end

    // sbag uses fire2 as a second start
    assign btn_start = keys[key_start] | (is_sbag & keys[key_fire2]);

    // player 1 flags botanic, only player 0 carries the coin
    assign bit1 = (player_idx == 1) ? is_botanic : 1'b0;
    assign bit0 = (player_idx == 0) ? keys[key_coin] : 1'b0;

    // active high view, inverted on the way out
    assign joy_hi = {keys[key_fire1], vert, keys[key_right], keys[key_left],
                     btn_start, bit1, bit0};

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            // all released
            joy_port <= '1;
        end else begin
            joy_port <= ~joy_hi;
        end
    end

endmodule

`default_nettype wire

/* hw/cfg_regs.sv */
//////////////////////////////////////////////////////////////////////
// bridge write decode for variant, DIP and reset toggle registers
// plus the stretcher that turns a toggle into one core reset pulse
//////////////////////////////////////////////////////////////////////

`default_nettype none

module cfg_regs
    import core_cfg_pkg::*;
(
    input  wire logic         clk_74a,
    input  wire logic         rst_n,
    input  wire logic         bridge_wr,
    input  wire bridge_addr_t bridge_addr,
    input  wire bridge_data_t bridge_wr_data,
    output mode_t             mode,
    output dip_t              dips,
    output logic              core_reset
);

    logic         wr_mode;
    logic         wr_dips;
    logic         wr_reset;
    logic         toggle;
    logic         toggle_prev;
    reset_count_t reset_count;

    // exact address match, qualified by the write strobe
    assign wr_mode  = bridge_wr && (bridge_addr == addr_mode);
    assign wr_dips  = bridge_wr && (bridge_addr == addr_dips);
    assign wr_reset = bridge_wr && (bridge_addr == addr_reset);

    //////////////////////////////////////////////////////////////////
    // config registers
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            mode   <= mode_bagman;
            dips   <= '0;
            toggle <= 1'b0;
        end else begin
            // low bits only, upper data ignored
            if (wr_mode) begin
                mode <= mode_t'(bridge_wr_data[$bits(mode_t)-1:0]);
            end
            if (wr_dips) begin
                dips <= bridge_wr_data[$bits(dip_t)-1:0];
            end
            // each write flips, the data word does not matter
            if (wr_reset) begin
                toggle <= ~toggle;
            end
        end
    end

    //////////////////////////////////////////////////////////////////
    // reset stretcher
    //////////////////////////////////////////////////////////////////

    // edge seen one clock after the flip
    // toggles inside a running pulse are absorbed by toggle_prev
    always_ff @(posedge clk_74a) begin
        if (!rst_n) begin
            toggle_prev <= 1'b0;
            core_reset  <= 1'b0;
            reset_count <= '0;
        end else begin
            toggle_prev <= toggle;
            if (!core_reset && (toggle != toggle_prev)) begin
                core_reset  <= 1'b1;
                reset_count <= reset_count_t'(1);
            end else if (core_reset) begin
                // count 1..reset_pulse_cycles while high
                if (reset_count == reset_count_t'(reset_pulse_cycles)) begin
                    core_reset  <= 1'b0;
                    reset_count <= '0;
                end else begin
                    reset_count <= reset_count + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/core_io_pkg.sv */
//////////////////////////////////////////////////////////////////////
// player and audio/video side definitions for the bagman shell
// controller key bits, joystick port, colour and sound widths
//////////////////////////////////////////////////////////////////////

`default_nettype none

package core_io_pkg;

    // controller key map from the bridge
    typedef logic [15:0] key_t;

    // active low joystick port of the core
    typedef logic [7:0] joy_port_t;

    // key bit positions
    localparam int key_up    = 0;
    localparam int key_down  = 1;
    localparam int key_left  = 2;
    localparam int key_right = 3;
    localparam int key_fire1 = 4;
    localparam int key_fire2 = 5;
    // select button acts as coin
    localparam int key_coin  = 14;
    localparam int key_start = 15;

    // core pixel is 3-3-2
    typedef logic [2:0] color3_t;
    typedef logic [1:0] color2_t;

    // scaler side colour, 8 bits per channel
    typedef logic [23:0] rgb_t;

    // core sound, unsigned with midpoint near 4096
    typedef logic [12:0] sound_t;

    // signed pcm sample
    typedef logic signed [15:0] sample_t;

    // removes the dc bias of the core sound
    localparam sample_t sound_offset = 16'sd4096;

    // dark green shown in blanking for squa
    localparam rgb_t squa_backdrop = 24'h00_20_00;

    // player count of the cabinet
    localparam int num_players = 2;

endpackage

`default_nettype wire

/* hw/core_cfg_pkg.sv */
//////////////////////////////////////////////////////////////////////
// configuration side definitions for the bagman shell
// bridge address map, game variant encoding, DIP byte type
// and the core reset pulse length
//////////////////////////////////////////////////////////////////////

`default_nettype none

package core_cfg_pkg;

    // bridge bus words
    typedef logic [31:0] bridge_addr_t;
    typedef logic [31:0] bridge_data_t;

    // dip switch byte handed to the core as is
    typedef logic [7:0] dip_t;

    // game variant
    // codes 5..7 have no name and fall back to bagman behaviour
    typedef enum logic [2:0] {
        mode_bagman  = 3'd0,
        mode_botanic = 3'd1,
        mode_pick    = 3'd2,
        mode_squa    = 3'd3,
        mode_sbag    = 3'd4
    } mode_t;

    // register map, exact match decode
    localparam bridge_addr_t addr_mode  = 32'h1000_0000;
    localparam bridge_addr_t addr_dips  = 32'h2000_0000;
    localparam bridge_addr_t addr_reset = 32'h3000_0000;

    // core reset pulse, in clk_74a cycles
    localparam int reset_pulse_cycles = 64;

    // must reach reset_pulse_cycles itself
    typedef logic [6:0] reset_count_t;

endpackage

`default_nettype wire
